//--- files.f
+incdir+.
mult_pkg.sv
job_ram.sv
job_sequencer.sv
shift_add_multiplier.sv
seg7_decoder.sv
mult_demo_top.sv
tb_mult_demo.sv

//--- job_ram.sv
// ==============================
// 32x32 dual-port job RAM with one-cycle registered reads
// both ports writing one address in a cycle is undefined
// ==============================
`include "mult_cfg.svh"

module job_ram (
        input  logic                      clk,
        input  mult_pkg::ram_req_t        host_req,    // host side while run is low
        output logic [`MULT_DATA_W-1:0]   host_rdata,
        input  mult_pkg::ram_req_t        seq_req,     // job sequencer side
        output logic [`MULT_DATA_W-1:0]   seq_rdata
);
        // operand slots 0..15 and result slots 16..31
        logic [`MULT_DATA_W-1:0] mem [`MULT_RAM_DEPTH];

        // ==============================
        // both ports on the one clock
        // ==============================
        always_ff @(posedge clk) begin
                if (host_req.we) begin
                        mem[host_req.addr] <= host_req.wdata;
                end
                if (seq_req.we) begin
                        mem[seq_req.addr] <= seq_req.wdata;
                end

                // read-during-write returns old data
                host_rdata <= mem[host_req.addr];
                seq_rdata  <= mem[seq_req.addr];
        end

endmodule

//--- job_sequencer.sv
// ==============================
// walks job slots 0..15 while run is high
// a run drop mid-batch is only seen once the batch has finished
// ==============================
`include "mult_cfg.svh"

module job_sequencer (
        input  logic                      clk,
        input  logic                      rst,
        input  logic                      run,         // level, host hands over the RAM
        output mult_pkg::ram_req_t        seq_req,
        input  logic [`MULT_DATA_W-1:0]   seq_rdata,
        output logic                      start,       // one-cycle pulse
        output logic [`MULT_OPND_W-1:0]   opnd_a,
        output logic [`MULT_OPND_W-1:0]   opnd_b,
        input  logic                      done,
        input  logic [`MULT_PROD_W-1:0]   product,
        output logic                      batch_done
);
        import mult_pkg::*;

        localparam int JOB_W = $clog2(`MULT_JOB_COUNT);

        seq_state_e       state;
        logic [JOB_W-1:0] job_idx;             // current slot
        logic             last_job;
        job_word_u        rd_word;             // operand view of the fetched word
        job_word_u        wr_word;             // result view of the stored word

        logic [`MULT_ADDR_W-1:0] opnd_addr;
        logic [`MULT_ADDR_W-1:0] result_addr;

        assign rd_word     = seq_rdata;
        assign last_job    = (job_idx == JOB_W'(`MULT_JOB_COUNT - 1));
        assign opnd_addr   = `MULT_ADDR_W'(job_idx);
        assign result_addr = `MULT_ADDR_W'(`MULT_RESULT_BASE) + `MULT_ADDR_W'(job_idx);

        // product in the low byte, pad forced to zero
        always_comb begin
                wr_word                = '0;
                wr_word.result.product = product;
        end

        // ==============================
        // RAM port, decoded from state
        // ==============================
        always_comb begin
                seq_req.we    = (state == SQ_STORE);
                seq_req.addr  = (state == SQ_STORE) ? result_addr : opnd_addr;
                seq_req.wdata = wr_word;
        end

        assign batch_done = (state == SQ_FINISHED);    // held until run drops

        // ==============================
        // batch FSM
        // ==============================
        always_ff @(posedge clk) begin
                if (rst) begin
                        state   <= SQ_IDLE;
                        job_idx <= '0;
                        start   <= 1'b0;
                        opnd_a  <= '0;
                        opnd_b  <= '0;
                end else begin
                        start <= 1'b0;                  // default, pulse only
                        case (state)
                        SQ_IDLE: begin
                                if (run) begin
                                        job_idx <= '0;  // every batch from slot 0
                                        state   <= SQ_FETCH;
                                end
                        end
                        SQ_FETCH: begin
                                state <= SQ_LOAD;       // address out this cycle
                        end
                        SQ_LOAD: begin
                                // read data valid now
                                opnd_a <= rd_word.opnd.a;
                                opnd_b <= rd_word.opnd.b;
                                start  <= 1'b1;
                                state  <= SQ_MULT;
                        end
                        SQ_MULT: begin
                                if (done) begin
                                        state <= SQ_STORE;
                                end
                        end
                        SQ_STORE: begin
                                // product still held by the multiplier here
                                if (last_job) begin
                                        state <= SQ_FINISHED;
                                end else begin
                                        job_idx <= job_idx + 1'b1;
                                        state   <= SQ_FETCH;
                                end
                        end
                        SQ_FINISHED: begin
                                if (!run) begin
                                        state <= SQ_IDLE;
                                end
                        end
                        default: state <= SQ_IDLE;
                        endcase
                end
        end

endmodule

//--- mult_cfg.svh
// ==============================
// sizes for the batch multiplier demo
// operand and product widths are fixed by the 4x4 multiplier
// ==============================
`ifndef MULT_CFG_SVH
`define MULT_CFG_SVH

// job RAM geometry
`define MULT_RAM_DEPTH   32
`define MULT_ADDR_W      5
`define MULT_DATA_W      32

`define MULT_OPND_W      4              // one operand nibble
`define MULT_PROD_W      8              // full 4x4 product
`define MULT_STATE_W     4              // state code shown on a digit

// batch layout, operands low half, results high half
`define MULT_JOB_COUNT   16
`define MULT_RESULT_BASE 16

`define SEG_W            7              // gfedcba, no decimal point
`endif

//--- mult_demo_top.sv
// ==============================
// batch multiplier demo top, host owns the RAM while run is low
// hex3 stays blank
// ==============================
`include "mult_cfg.svh"

module mult_demo_top (
        input  logic                      clk,
        input  logic                      rst,
        input  logic                      run,
        input  mult_pkg::ram_req_t        host_req,
        output logic [`MULT_DATA_W-1:0]   host_rdata,
        output logic                      batch_done,
        output logic [`SEG_W-1:0]         hex0,        // operand a
        output logic [`SEG_W-1:0]         hex1,        // operand b
        output logic [`SEG_W-1:0]         hex2,        // multiplier state code
        output logic [`SEG_W-1:0]         hex3
);
        import mult_pkg::*;

        ram_req_t                seq_req;
        logic [`MULT_DATA_W-1:0] seq_rdata;
        logic                    start;
        logic                    done;
        logic [`MULT_OPND_W-1:0] opnd_a;
        logic [`MULT_OPND_W-1:0] opnd_b;
        logic [`MULT_PROD_W-1:0] product;
        mult_state_e             mult_state;

        // ==============================
        // RAM, sequencer, multiplier
        // ==============================
        job_ram u_job_ram (
                .clk        (clk),
                .host_req   (host_req),
                .host_rdata (host_rdata),
                .seq_req    (seq_req),
                .seq_rdata  (seq_rdata)
        );

        job_sequencer u_job_sequencer (
                .clk        (clk),
                .rst        (rst),
                .run        (run),
                .seq_req    (seq_req),
                .seq_rdata  (seq_rdata),
                .start      (start),
                .opnd_a     (opnd_a),
                .opnd_b     (opnd_b),
                .done       (done),
                .product    (product),
                .batch_done (batch_done)
        );

        shift_add_multiplier u_mult (
                .clk     (clk),
                .rst     (rst),
                .start   (start),
                .a       (opnd_a),
                .b       (opnd_b),
                .product (product),
                .done    (done),
                .state   (mult_state)
        );

        // display
        seg7_decoder u_seg_a     (.digit(opnd_a),     .seg(hex0));
        seg7_decoder u_seg_b     (.digit(opnd_b),     .seg(hex1));
        seg7_decoder u_seg_state (.digit(mult_state), .seg(hex2));

        assign hex3 = {`SEG_W{1'b1}};          // all segments off

endmodule

//--- mult_pkg.sv
// ==============================
// shared types for the batch multiplier demo
// ==============================
`include "mult_cfg.svh"

package mult_pkg;

        // one port request into the job RAM
        typedef struct packed {
                logic                    we;
                logic [`MULT_ADDR_W-1:0] addr;
                logic [`MULT_DATA_W-1:0] wdata;
        } ram_req_t;

        // operand slot, a sits in the low nibble
        typedef struct packed {
                logic [`MULT_DATA_W-2*`MULT_OPND_W-1:0] pad;
                logic [`MULT_OPND_W-1:0]               b;
                logic [`MULT_OPND_W-1:0]               a;
        } job_opnd_t;

        typedef struct packed {
                logic [`MULT_DATA_W-`MULT_PROD_W-1:0] pad;   // zero on write
                logic [`MULT_PROD_W-1:0]             product;
        } job_result_t;

        // same RAM word, seen as operands or as a result
        typedef union packed {
                job_opnd_t   opnd;
                job_result_t result;
        } job_word_u;

        typedef enum logic [`MULT_STATE_W-1:0] {
                MS_IDLE  = 4'd0,
                MS_STEP0 = 4'd1,
                MS_STEP1 = 4'd2,
                MS_STEP2 = 4'd3,
                MS_STEP3 = 4'd4,
                MS_DONE  = 4'd5
        } mult_state_e;

        typedef enum logic [2:0] {
                SQ_IDLE, SQ_FETCH, SQ_LOAD, SQ_MULT, SQ_STORE, SQ_FINISHED
        } seq_state_e;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the batch multiplier testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_mult_demo -f files.f -o tb_mult_demo

./obj_dir/tb_mult_demo | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
        echo "simulation reported failure"
        exit 1
fi

echo "simulation finished without failure"
exit 0

//--- seg7_decoder.sv
// ==============================
// hex digit to active-low segments, bit order gfedcba
// ==============================
`include "mult_cfg.svh"

module seg7_decoder (
        input  logic [3:0]        digit,
        output logic [`SEG_W-1:0] seg          // low lights a segment
);
        always_comb begin
                case (digit)
                4'h0: seg = 7'h40;
                4'h1: seg = 7'h79;
                4'h2: seg = 7'h24;
                4'h3: seg = 7'h30;
                4'h4: seg = 7'h19;
                4'h5: seg = 7'h12;
                4'h6: seg = 7'h02;
                4'h7: seg = 7'h78;
                4'h8: seg = 7'h00;              // all on
                4'h9: seg = 7'h10;
                4'ha: seg = 7'h08;
                4'hb: seg = 7'h03;              // lower case b
                4'hc: seg = 7'h46;
                4'hd: seg = 7'h21;              // lower case d
                4'he: seg = 7'h06;
                default: seg = 7'h0e;           // F
                endcase
        end

endmodule

//--- shift_add_multiplier.sv
// ==============================
// 4x4 shift-add multiplier, start to done is six edges
// product is held until the next start
// ==============================
`include "mult_cfg.svh"

module shift_add_multiplier (
        input  logic                      clk,
        input  logic                      rst,
        input  logic                      start,       // sampled in MS_IDLE only
        input  logic [`MULT_OPND_W-1:0]   a,
        input  logic [`MULT_OPND_W-1:0]   b,
        output logic [`MULT_PROD_W-1:0]   product,
        output logic                      done,        // one-cycle pulse
        output mult_pkg::mult_state_e     state
);
        import mult_pkg::*;

        logic [`MULT_PROD_W-1:0] mcand;        // multiplicand, shifts left per step
        logic [`MULT_OPND_W-1:0] mplier;       // multiplier, shifts right per step
        logic [`MULT_PROD_W-1:0] acc;
        logic                    load;
        logic                    stepping;

        assign load     = (state == MS_IDLE) && start;
        assign stepping = state inside {MS_STEP0, MS_STEP1, MS_STEP2, MS_STEP3};
        assign product  = acc;

        // ==============================
        // state code, one value per step
        // ==============================
        always_ff @(posedge clk) begin
                if (rst) begin
                        state <= MS_IDLE;
                        done  <= 1'b0;
                end else begin
                        done <= 1'b0;
                        case (state)
                        MS_IDLE:  if (start) state <= MS_STEP0;
                        MS_STEP0: state <= MS_STEP1;
                        MS_STEP1: state <= MS_STEP2;
                        MS_STEP2: state <= MS_STEP3;
                        MS_STEP3: state <= MS_DONE;
                        MS_DONE: begin
                                state <= MS_IDLE;
                                done  <= 1'b1;      // acc settled one edge ago
                        end
                        default:  state <= MS_IDLE;
                        endcase
                end
        end

        // datapath
        always_ff @(posedge clk) begin
                if (load) begin
                        mcand  <= `MULT_PROD_W'(a);
                        mplier <= b;
                        acc    <= '0;
                end else if (stepping) begin
                        if (mplier[0]) begin
                                acc <= acc + mcand;     // partial product for this bit
                        end
                        mcand  <= mcand << 1;
                        mplier <= mplier >> 1;
                end
        end

endmodule

//--- tb_mult_demo.sv
// ==============================
// self-checking testbench for the batch multiplier demo
// host touches the RAM only while run is low
// ==============================
`include "mult_cfg.svh"

module tb_mult_demo;
        import mult_pkg::*;

        localparam int JOB_CYCLES = 12;                 // about 10 used per job
        localparam int IO_CYCLES  = 16 + 32 * 3;        // loads plus readback per batch
        localparam int WATCHDOG_CYCLES = 4 * (`MULT_JOB_COUNT * JOB_CYCLES + IO_CYCLES) + 50;

        logic                    clk;
        logic                    rst;
        logic                    run;
        ram_req_t                host_req;
        logic [`MULT_DATA_W-1:0] host_rdata;
        logic                    batch_done;
        logic [`SEG_W-1:0]       hex0;
        logic [`SEG_W-1:0]       hex1;
        logic [`SEG_W-1:0]       hex2;
        logic [`SEG_W-1:0]       hex3;

        logic [31:0] rng;                               // xorshift state
        logic [31:0] opnd_words [`MULT_JOB_COUNT];      // what the host wrote
        int          errors;
        int          fall_errors;                       // late batch_done fall
        int          checks;

        mult_demo_top u_mult_demo_top (
                .clk        (clk),
                .rst        (rst),
                .run        (run),
                .host_req   (host_req),
                .host_rdata (host_rdata),
                .batch_done (batch_done),
                .hex0       (hex0),
                .hex1       (hex1),
                .hex2       (hex2),
                .hex3       (hex3)
        );

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;                  // period 8
        end

        // batch_done must drop on the edge after run is seen low
        assert property (@(posedge clk) disable iff (rst) (batch_done && !run) |=> !batch_done)
        else begin
                fall_errors++;
                $display("ERROR batch_done fall expected %0d actual %0d",
                         1'b0, $sampled(batch_done));
        end

        // ==============================
        // helpers
        // ==============================
        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                y = y ^ (y << 5);
                return y;
        endfunction

        // active low in gfedcba order
        function automatic logic [6:0] seg_pattern(input logic [3:0] d);
                case (d)
                4'h0: return 7'h40;
                4'h1: return 7'h79;
                4'h2: return 7'h24;
                4'h3: return 7'h30;
                4'h4: return 7'h19;
                4'h5: return 7'h12;
                4'h6: return 7'h02;
                4'h7: return 7'h78;
                4'h8: return 7'h00;
                4'h9: return 7'h10;
                4'ha: return 7'h08;
                4'hb: return 7'h03;
                4'hc: return 7'h46;
                4'hd: return 7'h21;
                4'he: return 7'h06;
                default: return 7'h0e;
                endcase
        endfunction

        task automatic check_value(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
                checks++;
                assert (actual === expected)
                else begin
                        errors++;
                        $display("ERROR %s expected %h actual %h", name, expected, actual);
                end
        endtask

        task automatic write_word(input logic [`MULT_ADDR_W-1:0] addr, input logic [31:0] data);
                ram_req_t req;
                req.we    = 1'b1;
                req.addr  = addr;
                req.wdata = data;
                @(posedge clk);
                host_req <= req;
        endtask

        // registered read with data sampled at the falling edge
        task automatic read_word(input logic [`MULT_ADDR_W-1:0] addr, output logic [31:0] data);
                ram_req_t req;
                req.we    = 1'b0;
                req.addr  = addr;
                req.wdata = '0;
                @(posedge clk);
                host_req <= req;
                @(posedge clk);
                @(negedge clk);
                data = host_rdata;
        endtask

        task automatic fill_random();
                for (int i = 0; i < `MULT_JOB_COUNT; i++) begin
                        rng           = xorshift32(rng);
                        opnd_words[i] = rng;            // pad bits random too
                end
        endtask

        task automatic set_corner(input int slot, input logic [3:0] a, input logic [3:0] b);
                opnd_words[slot] = {opnd_words[slot][31:8], b, a};
        endtask

        task automatic load_operands();
                for (int i = 0; i < `MULT_JOB_COUNT; i++) begin
                        write_word(`MULT_ADDR_W'(i), opnd_words[i]);
                end
                @(posedge clk);
                host_req <= '0;
        endtask

        // raise run, wait for batch_done, check display, then hand the RAM back
        task automatic run_batch(input string tag);
                logic [3:0] a_last;
                logic [3:0] b_last;
                a_last = opnd_words[`MULT_JOB_COUNT-1][3:0];
                b_last = opnd_words[`MULT_JOB_COUNT-1][7:4];
                @(posedge clk);
                run <= 1'b1;
                while (!batch_done) @(negedge clk);
                check_value({tag, " hex0 last a"}, 32'(seg_pattern(a_last)), 32'(hex0));
                check_value({tag, " hex1 last b"}, 32'(seg_pattern(b_last)), 32'(hex1));
                check_value({tag, " hex2 idle"}, 32'(seg_pattern(4'h0)), 32'(hex2));
                @(posedge clk);
                run <= 1'b0;
                repeat (2) @(negedge clk);
                check_value({tag, " batch_done low"}, 32'd0, 32'(batch_done));
        endtask

        task automatic check_results(input string tag);
                logic [31:0] data;
                logic [7:0]  prod;
                for (int i = 0; i < `MULT_JOB_COUNT; i++) begin
                        prod = 8'(opnd_words[i][3:0]) * 8'(opnd_words[i][7:4]);
                        read_word(`MULT_ADDR_W'(`MULT_RESULT_BASE + i), data);
                        check_value($sformatf("%s result %0d", tag, i), {24'h0, prod}, data);
                end
        endtask

        task automatic check_operands(input string tag);
                logic [31:0] data;
                for (int i = 0; i < `MULT_JOB_COUNT; i++) begin
                        read_word(`MULT_ADDR_W'(i), data);
                        check_value($sformatf("%s operand %0d", tag, i), opnd_words[i], data);
                end
        endtask

        // ==============================
        // stimulus
        // ==============================
        initial begin
                rng         = 32'h16fa113e;
                errors      = 0;
                fall_errors = 0;
                checks      = 0;
                rst         = 1'b1;
                run         = 1'b0;
                host_req    = '0;
                repeat (5) @(posedge clk);
                rst <= 1'b0;
                @(negedge clk);

                check_value("reset batch_done", 32'd0, 32'(batch_done));
                check_value("reset hex0", 32'(seg_pattern(4'h0)), 32'(hex0));
                check_value("reset hex1", 32'(seg_pattern(4'h0)), 32'(hex1));
                check_value("reset hex2", 32'(seg_pattern(4'h0)), 32'(hex2));
                check_value("reset hex3", 32'h7f, 32'(hex3));   // blank

                fill_random();
                load_operands();
                run_batch("random");
                check_results("random");

                // corner operands in slots 0 to 4
                fill_random();
                set_corner(0, 4'd0, 4'd0);
                set_corner(1, 4'd0, 4'd15);
                set_corner(2, 4'd15, 4'd15);
                set_corner(3, 4'd1, 4'd15);
                set_corner(4, 4'd8, 4'd8);
                load_operands();
                run_batch("corner");
                check_results("corner");

                // restart with new data over old results
                fill_random();
                load_operands();
                run_batch("restart");
                check_results("restart");
                check_operands("restart");

                $display("errors: %0d  fall errors: %0d  checks: %0d", errors, fall_errors, checks);
                if (errors == 0 && fall_errors == 0) begin
                        $display("STATUS: PASS");
                end else begin
                        $display("STATUS: FAIL");
                end
                $finish;
        end

        // watchdog sized from batch and host traffic
        initial begin
                repeat (WATCHDOG_CYCLES + 5) @(posedge clk);
                $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
                $display("STATUS: FAIL");
                $finish;
        end

endmodule
